// File: hdl/rvPkg.sv
// shared types for the rv32i pipeline core
// word and register index types, alu and forwarding codes, opcodes, stage structs
package rvPkg;

	typedef logic [31:0] wordT; // data or address word
	typedef logic [4:0] regAddrT; // register index
	typedef logic [2:0] aluOpT;
	typedef logic [1:0] fwdSelT; // operand source select

	// alu operations
	localparam aluOpT aluAdd = 3'd0;
	localparam aluOpT aluSub = 3'd1;
	localparam aluOpT aluAnd = 3'd2;
	localparam aluOpT aluOr = 3'd3;
	localparam aluOpT aluSlt = 3'd4;

	// operand sources
	localparam fwdSelT fwdReg = 2'b00; // value read in decode
	localparam fwdSelT fwdWb = 2'b01; // writeback result
	localparam fwdSelT fwdMem = 2'b10; // memory stage alu result

	// major opcodes of the supported subset
	localparam logic [6:0] opRType = 7'b0110011;
	localparam logic [6:0] opIType = 7'b0010011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal = 7'b1101111;

	typedef struct packed {
		logic regWrite;
		logic memToReg; // result comes from data memory
		logic memWrite;
		logic aluSrc; // operand b is the immediate
		aluOpT aluOp;
		logic jump; // jal, result is the link value
		logic branch; // beq or bne
	} ctrlT;

	typedef struct packed {
		wordT instr;
		wordT pcPlus4;
	} ifIdT;

	typedef struct packed {
		ctrlT ctrl;
		wordT rs1Val;
		wordT rs2Val;
		wordT imm;
		regAddrT rs1;
		regAddrT rs2;
		regAddrT rd;
		wordT pcPlus4;
	} idExT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		wordT aluOut; // also the data address
		wordT storeData;
		regAddrT rd;
	} exMemT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		wordT aluOut;
		wordT readData;
		regAddrT rd;
	} memWbT;

endpackage

// File: hdl/fetchStage.sv
// fetch stage
// next pc select, pc register and if/id register
`timescale 1ns/1ps

module fetchStage #(
	parameter rvPkg::wordT resetPc = '0
) (
	input logic clk,
	input logic rstN,
	input logic stall, // hold pc and if/id
	input logic flush, // squash the fetched word
	input logic pcTaken,
	input rvPkg::wordT branchTarget,
	output rvPkg::wordT pcImem,
	input rvPkg::wordT imemInstr,
	output rvPkg::ifIdT ifId
);
	import rvPkg::*;

	wordT pc;
	wordT pcPlus4;
	wordT nextPc;

	assign pcPlus4 = pc + 32'd4;
	assign nextPc = pcTaken ? branchTarget : pcPlus4; // redirect from decode
	assign pcImem = pc;

	always_ff @(posedge clk) begin
		if (!rstN)
			pc <= resetPc;
		else if (!stall) // a stalled branch may not redirect yet
			pc <= nextPc;
	end

	// if/id register
	always_ff @(posedge clk) begin
		if (!rstN || flush) begin
			ifId <= '0; // zero word decodes as a nop
		end else if (!stall) begin
			ifId.instr <= imemInstr;
			ifId.pcPlus4 <= pcPlus4;
		end
	end

endmodule

// File: hdl/decodeStage.sv
// decode stage
// register file, immediates, branch compare and target, id/ex register
`timescale 1ns/1ps

module decodeStage (
	input logic clk,
	input logic rstN,
	input rvPkg::ifIdT ifId,
	input rvPkg::ctrlT ctrl,
	input logic bubble, // insert a nop into execute
	input logic fwdRs1,
	input logic fwdRs2,
	input rvPkg::wordT memAluOut,
	input logic wbEn,
	input rvPkg::regAddrT wbRd,
	input rvPkg::wordT wbData,
	output logic [6:0] opcode,
	output logic [2:0] funct3,
	output logic [6:0] funct7,
	output rvPkg::regAddrT rs1,
	output rvPkg::regAddrT rs2,
	output logic regsEqual,
	output rvPkg::wordT branchTarget,
	output rvPkg::idExT idEx
);
	import rvPkg::*;

	wordT regFile [32];
	wordT instr;
	regAddrT rd;
	wordT rs1Val, rs2Val; // after writeback bypass
	wordT rs1Cmp, rs2Cmp; // comparator operands
	wordT immI, immS, immB, immJ;
	wordT imm;

	assign instr = ifId.instr;

	// instruction fields
	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];

	// writes land on the rising edge, x0 never written
	always_ff @(posedge clk) begin
		if (wbEn && wbRd != '0)
			regFile[wbRd] <= wbData;
	end

	// reads see a same-cycle write
	always_comb begin
		if (rs1 == '0)
			rs1Val = '0;
		else if (wbEn && wbRd == rs1)
			rs1Val = wbData;
		else
			rs1Val = regFile[rs1];
		if (rs2 == '0)
			rs2Val = '0;
		else if (wbEn && wbRd == rs2)
			rs2Val = wbData;
		else
			rs2Val = regFile[rs2];
	end

	// immediate formats
	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		case (opcode)
			opStore: imm = immS;
			opBranch: imm = immB;
			opJal: imm = immJ;
			default: imm = immI; // op-imm and loads
		endcase
	end

	// branch compare sees the memory stage result early
	assign rs1Cmp = fwdRs1 ? memAluOut : rs1Val;
	assign rs2Cmp = fwdRs2 ? memAluOut : rs2Val;
	assign regsEqual = (rs1Cmp == rs2Cmp);

	// pc of this instruction plus offset
	assign branchTarget = (ifId.pcPlus4 - 32'd4) + imm;

	// id/ex register
	always_ff @(posedge clk) begin
		if (!rstN || bubble) begin
			idEx <= '0;
		end else begin
			idEx.ctrl <= ctrl;
			idEx.rs1Val <= rs1Val;
			idEx.rs2Val <= rs2Val;
			idEx.imm <= imm;
			idEx.rs1 <= rs1;
			idEx.rs2 <= rs2;
			idEx.rd <= rd;
			idEx.pcPlus4 <= ifId.pcPlus4;
		end
	end

endmodule

// File: hdl/controlDecoder.sv
// main control decoder
// opcode and funct fields to control struct, branch taken decision
`timescale 1ns/1ps

module controlDecoder (
	input logic [6:0] opcode,
	input logic [2:0] funct3,
	input logic [6:0] funct7,
	input logic regsEqual,
	output rvPkg::ctrlT ctrl,
	output logic pcTaken
);
	import rvPkg::*;

	aluOpT fieldOp; // alu op picked by funct3
	logic fieldOk; // funct3 is in the subset

	// shared by r-type and op-imm
	always_comb begin
		fieldOk = 1'b1;
		case (funct3)
			3'b000: fieldOp = (opcode == opRType && funct7[5]) ? aluSub : aluAdd;
			3'b010: fieldOp = aluSlt;
			3'b110: fieldOp = aluOr;
			3'b111: fieldOp = aluAnd;
			default: begin
				fieldOp = aluAdd;
				fieldOk = 1'b0; // unsupported, no write
			end
		endcase
	end

	always_comb begin
		ctrl = '0; // unknown opcodes do nothing
		case (opcode)
			opRType: begin
				ctrl.regWrite = fieldOk;
				ctrl.aluOp = fieldOp;
			end
			opIType: begin
				ctrl.regWrite = fieldOk;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = fieldOp;
			end
			opLoad: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = 1'b1; // base plus offset
			end
			opStore: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			opBranch: ctrl.branch = 1'b1;
			opJal: begin
				ctrl.regWrite = 1'b1; // link register
				ctrl.jump = 1'b1;
			end
			default: ;
		endcase
	end

	// beq on equal, bne on not equal
	assign pcTaken = ctrl.jump ||
		(ctrl.branch && ((funct3 == 3'b000 && regsEqual) || (funct3 == 3'b001 && !regsEqual)));

endmodule

// File: hdl/executeStage.sv
// execute stage
// operand forwarding muxes, alu, link value and ex/mem register
`timescale 1ns/1ps

module executeStage (
	input logic clk,
	input logic rstN,
	input rvPkg::idExT idEx,
	input rvPkg::fwdSelT fwdA,
	input rvPkg::fwdSelT fwdB,
	input rvPkg::wordT memAluOut,
	input rvPkg::wordT wbData,
	output rvPkg::exMemT exMem
);
	import rvPkg::*;

	wordT srcA, srcBReg, srcB;
	wordT aluRes, result;

	function automatic wordT fwdMux(fwdSelT sel, wordT regVal, wordT memVal, wordT wbVal);
		case (sel)
			fwdMem: return memVal;
			fwdWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign srcA = fwdMux(fwdA, idEx.rs1Val, memAluOut, wbData);
	assign srcBReg = fwdMux(fwdB, idEx.rs2Val, memAluOut, wbData); // also the store data
	assign srcB = idEx.ctrl.aluSrc ? idEx.imm : srcBReg;

	always_comb begin
		case (idEx.ctrl.aluOp)
			aluSub: aluRes = srcA - srcB;
			aluAnd: aluRes = srcA & srcB;
			aluOr: aluRes = srcA | srcB;
			aluSlt: aluRes = {31'b0, $signed(srcA) < $signed(srcB)};
			default: aluRes = srcA + srcB;
		endcase
	end

	// jal writes its return address
	assign result = idEx.ctrl.jump ? idEx.pcPlus4 : aluRes;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			exMem <= '0;
		end else begin
			exMem.regWrite <= idEx.ctrl.regWrite;
			exMem.memToReg <= idEx.ctrl.memToReg;
			exMem.memWrite <= idEx.ctrl.memWrite;
			exMem.aluOut <= result;
			exMem.storeData <= srcBReg;
			exMem.rd <= idEx.rd;
		end
	end

endmodule

// File: hdl/memWbStage.sv
// memory and writeback stages
// data memory drive, mem/wb register, result select
`timescale 1ns/1ps

module memWbStage (
	input logic clk,
	input logic rstN,
	input rvPkg::exMemT exMem,
	output logic dmemWe,
	output rvPkg::wordT dmemAddr,
	output rvPkg::wordT dmemWd,
	input rvPkg::wordT dmemRd,
	output logic wbEn,
	output rvPkg::regAddrT wbRd,
	output rvPkg::wordT wbData
);
	import rvPkg::*;

	memWbT memWb;

	assign dmemWe = exMem.memWrite; // written at the next edge
	assign dmemAddr = exMem.aluOut;
	assign dmemWd = exMem.storeData;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			memWb <= '0;
		end else begin
			memWb.regWrite <= exMem.regWrite;
			memWb.memToReg <= exMem.memToReg;
			memWb.aluOut <= exMem.aluOut;
			memWb.readData <= dmemRd; // combinational read
			memWb.rd <= exMem.rd;
		end
	end

	assign wbEn = memWb.regWrite;
	assign wbRd = memWb.rd;
	assign wbData = memWb.memToReg ? memWb.readData : memWb.aluOut;

endmodule

// File: hdl/hazardUnit.sv
// hazard unit
// forwarding selects, load-use and branch stalls, taken-branch flush
`timescale 1ns/1ps

module hazardUnit (
	input rvPkg::regAddrT rs1,
	input rvPkg::regAddrT rs2,
	input logic branchOp, // branch sitting in decode
	input logic pcTaken,
	input rvPkg::idExT idEx,
	input rvPkg::exMemT exMem,
	input logic wbEn,
	input rvPkg::regAddrT wbRd,
	output rvPkg::fwdSelT fwdA,
	output rvPkg::fwdSelT fwdB,
	output logic fwdRs1,
	output logic fwdRs2,
	output logic stall,
	output logic bubble,
	output logic flush
);
	import rvPkg::*;

	logic memHit1, memHit2, wbHit1, wbHit2;
	logic loadUse, exDep, memLoadDep;

	// execute forwarding, memory stage wins over writeback
	assign memHit1 = exMem.regWrite && exMem.rd != '0 && exMem.rd == idEx.rs1;
	assign memHit2 = exMem.regWrite && exMem.rd != '0 && exMem.rd == idEx.rs2;
	assign wbHit1 = wbEn && wbRd != '0 && wbRd == idEx.rs1;
	assign wbHit2 = wbEn && wbRd != '0 && wbRd == idEx.rs2;
	assign fwdA = memHit1 ? fwdMem : (wbHit1 ? fwdWb : fwdReg);
	assign fwdB = memHit2 ? fwdMem : (wbHit2 ? fwdWb : fwdReg);

	// decode comparator takes the memory stage alu result
	assign fwdRs1 = exMem.regWrite && exMem.rd != '0 && exMem.rd == rs1;
	assign fwdRs2 = exMem.regWrite && exMem.rd != '0 && exMem.rd == rs2;

	// load in execute feeding decode
	assign loadUse = idEx.ctrl.memToReg && idEx.rd != '0 && (idEx.rd == rs1 || idEx.rd == rs2);
	// producer directly ahead of a branch
	assign exDep = idEx.ctrl.regWrite && idEx.rd != '0 && (idEx.rd == rs1 || idEx.rd == rs2);
	// load result not ready until writeback
	assign memLoadDep = exMem.memToReg && exMem.rd != '0 && (exMem.rd == rs1 || exMem.rd == rs2);

	assign stall = loadUse || (branchOp && (exDep || memLoadDep));
	assign bubble = stall;
	assign flush = pcTaken && !stall; // drop the wrong-path fetch

endmodule

// File: hdl/riscvCore.sv
// top level of the five stage rv32i core
// stage, controller and hazard unit instances
`timescale 1ns/1ps

module riscvCore #(
	parameter rvPkg::wordT resetPc = '0 // first fetch address
) (
	input logic clk,
	input logic rstN,
	output rvPkg::wordT pcImem,
	input rvPkg::wordT imemInstr,
	output logic dmemWe,
	output rvPkg::wordT dmemAddr,
	output rvPkg::wordT dmemWd,
	input rvPkg::wordT dmemRd
);
	import rvPkg::*;

	// pipeline registers
	ifIdT ifId;
	idExT idEx;
	exMemT exMem;

	// decode to controller
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic regsEqual;
	ctrlT ctrl;
	logic pcTaken;
	wordT branchTarget;

	// hazard nets
	regAddrT rs1, rs2; // source indices in decode
	logic stall, bubble, flush;
	fwdSelT fwdA, fwdB;
	logic fwdRs1, fwdRs2;

	// writeback port back into decode and execute
	logic wbEn;
	regAddrT wbRd;
	wordT wbData;

	fetchStage #(.resetPc(resetPc)) u_fetch (
		.clk(clk), .rstN(rstN),
		.stall(stall), .flush(flush),
		.pcTaken(pcTaken), .branchTarget(branchTarget),
		.pcImem(pcImem), .imemInstr(imemInstr),
		.ifId(ifId)
	);

	decodeStage u_decode (
		.clk(clk), .rstN(rstN),
		.ifId(ifId), .ctrl(ctrl), .bubble(bubble),
		.fwdRs1(fwdRs1), .fwdRs2(fwdRs2), .memAluOut(exMem.aluOut),
		.wbEn(wbEn), .wbRd(wbRd), .wbData(wbData),
		.opcode(opcode), .funct3(funct3), .funct7(funct7),
		.rs1(rs1), .rs2(rs2), .regsEqual(regsEqual),
		.branchTarget(branchTarget), .idEx(idEx)
	);

	controlDecoder u_ctrl (
		.opcode(opcode), .funct3(funct3), .funct7(funct7),
		.regsEqual(regsEqual),
		.ctrl(ctrl), .pcTaken(pcTaken)
	);

	executeStage u_execute (
		.clk(clk), .rstN(rstN),
		.idEx(idEx), .fwdA(fwdA), .fwdB(fwdB),
		.memAluOut(exMem.aluOut), .wbData(wbData),
		.exMem(exMem)
	);

	memWbStage u_memWb (
		.clk(clk), .rstN(rstN),
		.exMem(exMem),
		.dmemWe(dmemWe), .dmemAddr(dmemAddr), .dmemWd(dmemWd), .dmemRd(dmemRd),
		.wbEn(wbEn), .wbRd(wbRd), .wbData(wbData)
	);

	hazardUnit u_hazard (
		.rs1(rs1), .rs2(rs2),
		.branchOp(ctrl.branch), .pcTaken(pcTaken),
		.idEx(idEx), .exMem(exMem),
		.wbEn(wbEn), .wbRd(wbRd),
		.fwdA(fwdA), .fwdB(fwdB),
		.fwdRs1(fwdRs1), .fwdRs2(fwdRs2),
		.stall(stall), .bubble(bubble), .flush(flush)
	);

endmodule

// File: test/riscvCore_chk.sv
// checker bound to the core
// reset, first fetch and store order assertions on the memory ports
`timescale 1ns/1ps

module riscvCore_chk #(
	parameter rvPkg::wordT resetPc = '0
) (
	input logic clk,
	input logic rstN,
	input rvPkg::wordT pcImem,
	input logic dmemWe,
	input rvPkg::wordT dmemAddr,
	input rvPkg::wordT dmemWd
);
	import rvPkg::*;

	int failCount = 0; // read by the testbench
	logic idxOk;
	wordT expAddr, expData;

	// next entry of the expected store table
	assign idxOk = tbTop.storeIdx < tbTop.numStores;
	assign expAddr = idxOk ? tbTop.expAddr[tbTop.storeIdx] : '0;
	assign expData = idxOk ? tbTop.expData[tbTop.storeIdx] : '0;

	// ex/mem clears at the first reset edge
	noStoreInReset: assert property (@(posedge clk) !rstN && !$past(rstN) |-> !dmemWe)
		else begin
			failCount++;
			$error("data memory written during reset at %0t", $time);
		end

	firstFetch: assert property (@(posedge clk) $rose(rstN) |-> pcImem == resetPc)
		else begin
			failCount++;
			$error("first fetch from %h, not the reset pc, at %0t", $sampled(pcImem), $time);
		end

	noExtraStore: assert property (@(posedge clk) disable iff (!rstN) dmemWe |-> idxOk)
		else begin
			failCount++;
			$error("a store beyond the expected ones reached memory at %0t", $time);
		end

	storeMatch: assert property (@(posedge clk) disable iff (!rstN)
			dmemWe && idxOk |-> dmemAddr == expAddr && dmemWd == expData)
		else begin
			failCount++;
			$error("Mismatch at %0t: wrote %h to %h, expected %h to %h", $time,
				$sampled(dmemWd), $sampled(dmemAddr), $sampled(expData), $sampled(expAddr));
		end

	noSkippedStore: assert property (@(posedge clk) disable iff (!rstN)
			dmemWe |-> dmemAddr != tbTop.poisonAddr)
		else begin
			failCount++;
			$error("a store behind a taken branch or jump executed at %0t", $time);
		end

endmodule

// File: test/tbTop.sv
// testbench for the pipeline core
// memories, program builder with expected stores, watchdog and report
`timescale 1ns/1ps

module tbTop;
	import rvPkg::*;

	localparam wordT poisonAddr = 32'h7f0; // only skipped stores write here
	localparam int resetCycles = 10;

	logic clk = 1'b0;
	logic rstN;
	logic dmemWe;
	wordT pcImem, imemInstr, dmemAddr, dmemWd, dmemRd;

	wordT imem [256];
	wordT dram [256];
	wordT regs [32]; // isa model of the register file
	wordT expAddr [32]; // expected stores in program order
	wordT expData [32];
	int expTest [32];
	int numStores = 0;
	int storeIdx = 0; // next expected store
	int progLen = 0;
	logic built = 1'b0;
	string testName [5] = '{"reset", "alu forwarding", "load use", "branches", "jal link"};

	riscvCore #(.resetPc(32'h0)) u_dut (
		.clk(clk), .rstN(rstN),
		.pcImem(pcImem), .imemInstr(imemInstr),
		.dmemWe(dmemWe), .dmemAddr(dmemAddr), .dmemWd(dmemWd), .dmemRd(dmemRd)
	);

	bind riscvCore riscvCore_chk #(.resetPc(resetPc)) u_chk (
		.clk(clk), .rstN(rstN), .pcImem(pcImem),
		.dmemWe(dmemWe), .dmemAddr(dmemAddr), .dmemWd(dmemWd)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	// both memories read combinationally
	assign imemInstr = imem[pcImem[9:2]];
	assign dmemRd = dram[dmemAddr[9:2]];

	always @(posedge clk) begin
		if (dmemWe)
			dram[dmemAddr[9:2]] <= dmemWd;
	end

	// a test ends with its last expected store
	always @(posedge clk) begin
		if (rstN && dmemWe) begin
			storeIdx <= storeIdx + 1;
			if (storeIdx < numStores && (storeIdx + 1 == numStores ||
					expTest[storeIdx + 1] != expTest[storeIdx]))
				$display("test %0d (%s) finished at %0t, store %0d", expTest[storeIdx],
					testName[expTest[storeIdx]], $time, storeIdx);
		end
	end

	function automatic wordT sext12(logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	// rv32i semantics for the supported funct3 codes
	function automatic wordT aluModel(logic [2:0] f3, logic isSub, wordT a, wordT b);
		case (f3)
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b110: return a | b;
			3'b111: return a & b;
			default: return isSub ? a - b : a + b;
		endcase
	endfunction

	task automatic emit(wordT instr);
		imem[progLen] = instr;
		progLen++;
	endtask

	task automatic aluR(logic [2:0] f3, logic isSub, regAddrT rd, regAddrT rs1, regAddrT rs2);
		emit({1'b0, isSub, 5'b0, rs2, rs1, f3, rd, opRType});
		regs[rd] = aluModel(f3, isSub, regs[rs1], regs[rs2]);
	endtask

	task automatic aluI(logic [2:0] f3, regAddrT rd, regAddrT rs1, logic [11:0] imm);
		emit({imm, rs1, f3, rd, opIType});
		regs[rd] = aluModel(f3, 1'b0, regs[rs1], sext12(imm));
	endtask

	// sw to the next free slot off x0
	task automatic store(regAddrT rs2, int test);
		wordT addr;
		addr = 32'h100 + 4 * numStores;
		emit({addr[11:5], rs2, 5'd0, 3'b010, addr[4:0], opStore});
		expAddr[numStores] = addr;
		expData[numStores] = regs[rs2];
		expTest[numStores] = test;
		numStores++;
	endtask

	task automatic poison();
		emit({poisonAddr[11:5], 5'd0, 5'd0, 3'b010, poisonAddr[4:0], opStore});
	endtask

	// lw back from an earlier slot
	task automatic load(regAddrT rd, int slot);
		emit({expAddr[slot][11:0], 5'd0, 3'b010, rd, opLoad});
		regs[rd] = expData[slot];
	endtask

	// offset 8 jumps over one slot, which stores only on fall through
	task automatic branch(logic bne, regAddrT rs1, regAddrT rs2, regAddrT slotReg, int test);
		logic taken;
		taken = bne ? (regs[rs1] != regs[rs2]) : (regs[rs1] == regs[rs2]);
		emit({1'b0, 6'd0, rs2, rs1, {2'b00, bne}, 4'b0100, 1'b0, opBranch});
		if (taken)
			poison();
		else
			store(slotReg, test);
	endtask

	task automatic jalSkip(regAddrT rd);
		regs[rd] = 4 * progLen + 4; // pc+4 with reset pc zero
		emit({1'b0, 10'd4, 1'b0, 8'd0, rd, opJal});
		poison();
	endtask

	task automatic buildProgram();
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		aluI(3'b000, 5'd1, 5'd0, 12'($urandom));
		store(5'd1, 0); // slot 0
		// each result feeds the next instruction
		aluI(3'b000, 5'd2, 5'd0, 12'($urandom));
		aluR(3'b000, 1'b0, 5'd3, 5'd1, 5'd2); // add
		aluR(3'b000, 1'b1, 5'd4, 5'd3, 5'd1); // sub
		aluR(3'b111, 1'b0, 5'd5, 5'd4, 5'd3);
		aluR(3'b110, 1'b0, 5'd6, 5'd5, 5'd2);
		aluR(3'b010, 1'b0, 5'd7, 5'd6, 5'd3); // slt
		aluI(3'b110, 5'd8, 5'd6, 12'($urandom));
		aluI(3'b111, 5'd9, 5'd8, 12'($urandom));
		store(5'd9, 1); // store data forwarded into slot 1
		store(5'd3, 1);
		store(5'd4, 1); // slot 3
		store(5'd5, 1);
		store(5'd6, 1); // slot 5
		store(5'd7, 1);
		load(5'd10, 3);
		aluR(3'b000, 1'b0, 5'd11, 5'd10, 5'd2); // load use
		store(5'd11, 2);
		load(5'd12, 5);
		store(5'd12, 2); // loaded value as store data
		aluI(3'b000, 5'd13, 5'd0, 12'($urandom));
		branch(1'b0, 5'd13, 5'd13, 5'd13, 3); // taken beq after a one cycle stall
		branch(1'b1, 5'd13, 5'd1, 5'd13, 3);
		load(5'd14, 2);
		branch(1'b1, 5'd14, 5'd3, 5'd14, 3); // falls through after two stalls
		store(5'd13, 3);
		jalSkip(5'd15);
		store(5'd15, 4);
		emit({20'd0, 5'd0, opJal}); // park on a self loop
	endtask

	initial begin
		void'($urandom(13));
		rstN = 1'b0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0; // zero word runs as a nop
			dram[i] = 32'hc0de0000 ^ (i * 4);
		end
		buildProgram();
		built = 1'b1;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
		wait (storeIdx == numStores);
		repeat (20) @(posedge clk); // room for a stray store
		$display("tests 5, stores %0d of %0d, assertion failures %0d",
			storeIdx, numStores, u_dut.u_chk.failCount);
		if (u_dut.u_chk.failCount == 0 && storeIdx == numStores)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// 20 cycles per instruction plus reset
	initial begin
		wait (built);
		#((progLen * 20 + resetCycles) * 10);
		$display("run timed out at %0t with %0d of %0d stores seen", $time, storeIdx, numStores);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: project.f
hdl/rvPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/controlDecoder.sv
hdl/executeStage.sv
hdl/memWbStage.sv
hdl/hazardUnit.sv
hdl/riscvCore.sv
test/riscvCore_chk.sv
test/tbTop.sv

// File: Makefile
# Verilator build and run for the pipeline core testbench

VERILATOR ?= verilator
TOP ?= tbTop
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: compile
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
